//--- tb/gbt_link_testdata.txt
// columns: ttc corrupt wr_valid wr_en b2b addr data exp_err exp_data
// one hex word per line, fields split by underscores; b2b=1 means no idle gap before
// writes to valid registers
a_0_1_1_0_0000_deadbeef_0_deadbeef
0_0_1_1_0_0001_12345678_0_12345678
5_0_1_1_0_0005_a5a55a5a_0_a5a55a5a
0_0_1_1_0_000f_ffffffff_0_ffffffff
// read back
3_0_1_0_0_0000_00000000_0_deadbeef
0_0_1_0_0_0001_00000000_0_12345678
0_0_1_0_0_0005_00000000_0_a5a55a5a
0_0_1_0_0_000f_00000000_0_ffffffff
0_0_1_0_0_0007_00000000_0_00000000
// bad addresses, registers untouched
8_0_1_1_0_0105_cafef00d_1_00000000
0_0_1_0_0_0005_00000000_0_a5a55a5a
0_0_1_0_0_8000_00000000_1_00000000
4_0_1_1_0_fff3_11111111_1_00000000
0_0_1_0_0_0003_00000000_0_00000000
// corrupt frames
2_1_1_1_0_0003_77777777_0_00000000
0_0_1_0_0_0003_00000000_0_00000000
1_1_0_0_0_0000_00000000_0_00000000
// no request
f_0_0_1_0_0002_55555555_0_00000000
0_0_1_0_0_0002_00000000_0_00000000
// back to back
0_0_1_1_1_0008_01234567_0_01234567
9_0_1_1_1_0009_89abcdef_0_89abcdef
6_0_1_0_1_0008_00000000_0_01234567
0_0_1_0_1_0009_00000000_0_89abcdef
c_0_1_0_1_0000_00000000_0_deadbeef
0_1_1_1_1_0004_13572468_0_00000000
0_0_1_0_1_0004_00000000_0_00000000
0_0_1_1_0_0004_0badc0de_0_0badc0de
0_0_1_0_1_0004_00000000_0_0badc0de

//--- vlog.f
+incdir+common
common/gbt_link_pkg.sv
gbt_rx/gbt_frame_decoder.sv
logic/reg_bank_exec.sv
logic/reply_framer.sv
logic/gbt_link_top.sv
tb/tb_clk_gen.sv
tb/gbt_link_tb.sv

//--- Makefile
# Verilator build and run of the link testbench

VERILATOR ?= verilator
TOP       ?= gbt_link_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status, so make fails
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/gbt_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbt_link_defines.svh"

module gbt_link_tb;

  localparam int MAX_LINES = 64;   // room in the vector memory
  localparam int MAX_CYC   = 2048; // room in the expected arrays
  localparam int TAIL_IDLE = 16;   // idle words after the last frame

  logic                      clk40;
  logic                      rst_n;
  gbt_link_pkg::elink_word_t gbt_rx_word;
  gbt_link_pkg::elink_word_t gbt_tx_word;
  logic                      l1a;
  logic                      calpulse;
  logic                      resync;
  logic                      bc0;
  logic                      frame_err;

  logic [103:0] vecs [MAX_LINES]; // one packed request per entry

  // expected outputs, indexed by the rising edge that samples them
  gbt_link_pkg::elink_word_t want_tx  [MAX_CYC];
  gbt_link_pkg::ttc_cmd_t    want_ttc [MAX_CYC];
  logic                      want_err [MAX_CYC];

  int                       cyc;       // rising edges since reset release
  int                       cyc_limit; // 0 until the vectors are loaded
  logic [31:0]              rng;
  gbt_link_pkg::reply_seq_t seq;       // number of the next reply

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(3)) u_tb_clk_gen (
    .clk_o   (clk40),
    .rst_n_o (rst_n)
  );

  gbt_link_top u_gbt_link_top (
    .clk40         (clk40),
    .rst_n_i       (rst_n),
    .gbt_rx_word_i (gbt_rx_word),
    .gbt_tx_word_o (gbt_tx_word),
    .l1a_o         (l1a),
    .calpulse_o    (calpulse),
    .resync_o      (resync),
    .bc0_o         (bc0),
    .frame_err_o   (frame_err)
  );

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13); // xorshift32
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word k of a frame: start, begin, addr0..addr2, data0..data4
  function automatic gbt_link_pkg::frame_field_t frame_field(
    input int                         k,
    input gbt_link_pkg::frame_field_t begin_f,
    input gbt_link_pkg::reg_addr_t    addr,
    input gbt_link_pkg::reg_data_t    data
  );
    case (k)
      0: return `GBT_FRAME_START;
      1: return begin_f;
      2: return addr[15:10];
      3: return addr[9:4];
      4: return {addr[3:0], data[31:30]};
      default: return data[29 - 6 * (k - 5) -: 6]; // data0 is the top six
    endcase
  endfunction

  // one word per falling edge; returns the edge that samples it
  task automatic drive_word(input gbt_link_pkg::elink_word_t w, output int edge_n);
    @(negedge clk40);
    gbt_rx_word = w;
    edge_n      = cyc + 1;
    want_ttc[edge_n + 1] = w[9:6]; // ttc strobes one edge later
  endtask

  task automatic check_word(input string name, input gbt_link_pkg::elink_word_t got,
                            input gbt_link_pkg::elink_word_t want);
    if (got !== want) begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic check_ttc(input string name, input gbt_link_pkg::ttc_cmd_t got,
                           input gbt_link_pkg::ttc_cmd_t want);
    if (got !== want) begin
      $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, want);
      abort_run();
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic run_frames(input int n_lines);
    int                         gap;
    int                         edge_n;
    logic [103:0]               v;
    gbt_link_pkg::ttc_cmd_t     ttc;
    gbt_link_pkg::reg_addr_t    addr;
    gbt_link_pkg::reg_data_t    data;
    gbt_link_pkg::reg_data_t    rsp_data;
    gbt_link_pkg::frame_field_t begin_f;
    gbt_link_pkg::frame_field_t rsp_begin;
    logic                       corrupt;
    logic                       wr_valid;
    logic                       wr_en;
    logic                       b2b;
    logic                       rsp_err;

    edge_n = 0;
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_lines; i++) begin
      v        = vecs[i];
      ttc      = v[103:100];
      corrupt  = v[96];
      wr_valid = v[92];
      wr_en    = v[88];
      b2b      = v[84];
      addr     = v[83:68];
      data     = v[67:36];
      rsp_err  = v[32];
      rsp_data = v[31:0];

      if (b2b) begin
        gap = 0;
      end else begin
        rng = next_random(rng);
        gap = int'(rng[1:0]); // 0 to 3 idle words
      end
      repeat (gap) begin
        drive_word({ttc, 6'h00}, edge_n);
      end

      begin_f = {wr_valid, wr_en, corrupt ? 4'b0110 : 4'b0000};
      for (int k = 0; k < `GBT_FRAME_WORDS; k++) begin
        drive_word({ttc, frame_field(k, begin_f, addr, data)}, edge_n);
      end

      // edge_n is now the data4 edge
      if (corrupt) begin
        want_err[edge_n + 1] = 1'b1; // dropped, no reply
      end else if (wr_valid) begin
        rsp_begin = {rsp_err, wr_en, 4'b0000};
        for (int k = 0; k < `GBT_FRAME_WORDS; k++) begin
          want_tx[edge_n + 3 + k] = {seq, frame_field(k, rsp_begin, addr, rsp_data)};
        end
        seq = seq + 4'd1;
      end
    end
    repeat (TAIL_IDLE) begin
      drive_word('0, edge_n); // let the last reply drain
    end
    @(posedge clk40);
  endtask

  initial begin : stimulus
    int n_lines;

    gbt_rx_word = '0;
    rng         = 32'hb54a;
    seq         = '0;
    for (int c = 0; c < MAX_CYC; c++) begin
      want_tx[c]  = '0;
      want_ttc[c] = '0;
      want_err[c] = 1'b0;
    end
    for (int i = 0; i < MAX_LINES; i++) begin
      vecs[i] = '1; // end marker, never a valid line
    end
    $readmemh("tb/gbt_link_testdata.txt", vecs);
    n_lines = 0;
    while (n_lines < MAX_LINES && vecs[n_lines] !== '1) begin
      n_lines++;
    end
    cyc_limit = 16 * n_lines + 50;

    if (n_lines == 0) begin
      $display("no test vectors could be read from tb/gbt_link_testdata.txt");
      abort_run();
    end else begin
      run_frames(n_lines);
      $display("PASS: all tests");
      $finish;
    end
  end

  // ------------------------------
  // monitor and timeout
  // ------------------------------

  // outputs settle after the rising edge, compare on the falling one
  // against what the next rising edge samples
  always @(negedge clk40) begin
    if (rst_n && cyc > 0 && cyc + 1 < MAX_CYC) begin
      check_word("gbt_tx_word_o", gbt_tx_word, want_tx[cyc + 1]);
      check_ttc("{l1a_o,calpulse_o,resync_o,bc0_o}", {l1a, calpulse, resync, bc0},
                want_ttc[cyc + 1]);
      check_flag("frame_err_o", frame_err, want_err[cyc + 1]);
    end
  end

  always @(posedge clk40 or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
      if (cyc_limit > 0 && cyc >= cyc_limit) begin
        $display("timeout: the test did not finish within %0d cycles", cyc_limit);
        abort_run();
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, same as the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/gbt_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module gbt_link_top (
  input  wire                       clk40,
  input  wire                       rst_n_i,
  input  wire gbt_link_pkg::elink_word_t gbt_rx_word_i,
  output wire gbt_link_pkg::elink_word_t gbt_tx_word_o,
  output wire                       l1a_o,
  output wire                       calpulse_o,
  output wire                       resync_o,
  output wire                       bc0_o,
  output wire                       frame_err_o
);

  // decoder -> execute
  logic                    req_stb;
  logic                    req_wr;
  gbt_link_pkg::reg_addr_t req_addr;
  gbt_link_pkg::reg_data_t req_data;

  // execute -> framer
  logic                    rsp_stb;
  logic                    rsp_wr;
  logic                    rsp_err;
  gbt_link_pkg::reg_addr_t rsp_addr;
  gbt_link_pkg::reg_data_t rsp_data;

  // ------------------------------
  // decode
  // ------------------------------

  gbt_frame_decoder u_gbt_frame_decoder (
    .clk40       (clk40),
    .rst_n_i     (rst_n_i),
    .rx_word_i   (gbt_rx_word_i),
    .l1a_o       (l1a_o),
    .calpulse_o  (calpulse_o),
    .resync_o    (resync_o),
    .bc0_o       (bc0_o),
    .req_stb_o   (req_stb),
    .req_wr_o    (req_wr),
    .req_addr_o  (req_addr),
    .req_data_o  (req_data),
    .frame_err_o (frame_err_o)
  );

  // ------------------------------
  // execute and reply
  // ------------------------------

  reg_bank_exec u_reg_bank_exec (
    .clk40      (clk40),
    .rst_n_i    (rst_n_i),
    .req_stb_i  (req_stb),
    .req_wr_i   (req_wr),
    .req_addr_i (req_addr),
    .req_data_i (req_data),
    .rsp_stb_o  (rsp_stb),
    .rsp_wr_o   (rsp_wr),
    .rsp_err_o  (rsp_err),
    .rsp_addr_o (rsp_addr),
    .rsp_data_o (rsp_data)
  );

  reply_framer u_reply_framer (
    .clk40      (clk40),
    .rst_n_i    (rst_n_i),
    .rsp_stb_i  (rsp_stb),
    .rsp_wr_i   (rsp_wr),
    .rsp_err_i  (rsp_err),
    .rsp_addr_i (rsp_addr),
    .rsp_data_i (rsp_data),
    .tx_word_o  (gbt_tx_word_o)
  );

endmodule

`default_nettype wire

//--- logic/reply_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbt_link_defines.svh"

module reply_framer (
  input  wire                     clk40,
  input  wire                     rst_n_i,
  input  wire                     rsp_stb_i,
  input  wire                     rsp_wr_i,
  input  wire                     rsp_err_i,
  input  wire gbt_link_pkg::reg_addr_t rsp_addr_i,
  input  wire gbt_link_pkg::reg_data_t rsp_data_i,
  output gbt_link_pkg::elink_word_t    tx_word_o
);

  localparam logic [3:0] LAST_IDX = 4'(`GBT_FRAME_WORDS - 1);

  logic                       busy;     // a reply word is on tx_word_o
  logic [3:0]                 word_idx; // index of the word on tx_word_o
  logic [3:0]                 nxt_idx;
  gbt_link_pkg::reply_seq_t   seq;
  gbt_link_pkg::frame_field_t nxt_field;

  // latched reply
  logic                    wr_q;
  logic                    err_q;
  gbt_link_pkg::reg_addr_t addr_q;
  gbt_link_pkg::reg_data_t data_q;

  always_ff @(posedge clk40) begin
    if (rsp_stb_i) begin
      wr_q   <= rsp_wr_i;
      err_q  <= rsp_err_i;
      addr_q <= rsp_addr_i;
      data_q <= rsp_data_i;
    end
  end

  // a new reply restarts at the start word
  assign nxt_idx = rsp_stb_i ? 4'd0 : word_idx + 4'd1;

  // ------------------------------
  // field select
  // ------------------------------

  always_comb begin
    case (nxt_idx)
      4'd0: nxt_field = `GBT_FRAME_START;
      4'd1: nxt_field = {err_q, wr_q, 4'b0000}; // begin word
      4'd2: nxt_field = addr_q[15:10];
      4'd3: nxt_field = addr_q[9:4];
      4'd4: nxt_field = {addr_q[3:0], data_q[31:30]};
      4'd5: nxt_field = data_q[29:24];
      4'd6: nxt_field = data_q[23:18];
      4'd7: nxt_field = data_q[17:12];
      4'd8: nxt_field = data_q[11:6];
      4'd9: nxt_field = data_q[5:0];
      default: nxt_field = '0;
    endcase
  end

  // ------------------------------
  // word counter and output
  // ------------------------------

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy      <= 1'b0;
      word_idx  <= '0;
      seq       <= '0;
      tx_word_o <= '0;
    end else if (rsp_stb_i || (busy && word_idx != LAST_IDX)) begin
      busy      <= 1'b1;
      word_idx  <= nxt_idx;
      tx_word_o <= {seq, nxt_field};
      if (nxt_idx == LAST_IDX) begin
        seq <= seq + 4'd1; // last word still carries the old count
      end
    end else begin
      busy      <= 1'b0;
      tx_word_o <= '0; // idle
    end
  end

  // replies must not overlap; earliest restart is while the last word is out
  a_no_overlap: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_stb_i |-> (!busy || word_idx == LAST_IDX))
    else $error("rsp_stb_i arrived while a reply was in progress");

endmodule

`default_nettype wire

//--- logic/reg_bank_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbt_link_defines.svh"

module reg_bank_exec (
  input  wire                     clk40,
  input  wire                     rst_n_i,
  input  wire                     req_stb_i,
  input  wire                     req_wr_i,
  input  wire gbt_link_pkg::reg_addr_t req_addr_i,
  input  wire gbt_link_pkg::reg_data_t req_data_i,
  output logic                    rsp_stb_o,
  output logic                    rsp_wr_o,
  output logic                    rsp_err_o,
  output gbt_link_pkg::reg_addr_t rsp_addr_o,
  output gbt_link_pkg::reg_data_t rsp_data_o
);

  gbt_link_pkg::reg_data_t   regs [`GBT_REG_COUNT];
  logic [`GBT_REG_IDX_W-1:0] idx;
  logic                      addr_ok; // upper address bits all zero

  assign idx     = req_addr_i[`GBT_REG_IDX_W-1:0];
  assign addr_ok = ~|req_addr_i[15:`GBT_REG_IDX_W];

  // ------------------------------
  // register bank
  // ------------------------------

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `GBT_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (req_stb_i && req_wr_i && addr_ok) begin
      regs[idx] <= req_data_i;
    end
  end

  // ------------------------------
  // response
  // ------------------------------

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_stb_o <= 1'b0;
      rsp_wr_o  <= 1'b0;
      rsp_err_o <= 1'b0;
    end else begin
      rsp_stb_o <= req_stb_i; // one cycle behind the request
      if (req_stb_i) begin
        rsp_wr_o  <= req_wr_i;
        rsp_err_o <= ~addr_ok;
      end
    end
  end

  always_ff @(posedge clk40) begin
    if (req_stb_i) begin
      rsp_addr_o <= req_addr_i;
      if (!addr_ok) begin
        rsp_data_o <= '0;          // bad address returns zero
      end else if (req_wr_i) begin
        rsp_data_o <= req_data_i;  // echo written data
      end else begin
        rsp_data_o <= regs[idx];
      end
    end
  end

  // good responses carry what the addressed register now holds
  a_rsp_matches_bank: assert property (@(posedge clk40) disable iff (!rst_n_i)
    (rsp_stb_o && !rsp_err_o) |-> (rsp_data_o == regs[rsp_addr_o[`GBT_REG_IDX_W-1:0]]))
    else $error("rsp_data_o differs from the addressed register");

endmodule

`default_nettype wire

//--- gbt_rx/gbt_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbt_link_defines.svh"

module gbt_frame_decoder (
  input  wire                      clk40,
  input  wire                      rst_n_i,
  input  wire gbt_link_pkg::elink_word_t rx_word_i,
  output logic                     l1a_o,
  output logic                     calpulse_o,
  output logic                     resync_o,
  output logic                     bc0_o,
  output logic                     req_stb_o,
  output logic                     req_wr_o,
  output gbt_link_pkg::reg_addr_t  req_addr_o,
  output gbt_link_pkg::reg_data_t  req_data_o,
  output logic                     frame_err_o
);

  // index of the data4 word inside a frame
  localparam logic [3:0] LAST_CNT = 4'(`GBT_FRAME_WORDS - 1);

  gbt_link_pkg::dec_state_t   state;
  logic [3:0]                 word_cnt;   // index of the word being sampled
  gbt_link_pkg::frame_field_t fld;
  gbt_link_pkg::ttc_cmd_t     ttc_q;
  logic                       wr_valid_q; // from the begin word
  logic                       wr_en_q;
  logic                       rsvd_err_q; // reserved bits were nonzero
  gbt_link_pkg::reg_addr_t    addr_q;
  gbt_link_pkg::reg_data_t    data_q;     // data bits shift in msb first

  assign fld = rx_word_i[5:0];

  // ------------------------------
  // ttc, registered in every state
  // ------------------------------

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ttc_q <= '0;
    end else begin
      ttc_q <= rx_word_i[9:6];
    end
  end

  assign l1a_o      = ttc_q[3];
  assign calpulse_o = ttc_q[2];
  assign resync_o   = ttc_q[1];
  assign bc0_o      = ttc_q[0];

  // ------------------------------
  // frame hunt and word count
  // ------------------------------

  always_ff @(posedge clk40 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state       <= gbt_link_pkg::st_hunt;
      word_cnt    <= '0;
      wr_valid_q  <= 1'b0;
      rsvd_err_q  <= 1'b0;
      req_stb_o   <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      req_stb_o   <= 1'b0; // single cycle strobes
      frame_err_o <= 1'b0;
      case (state)
        gbt_link_pkg::st_hunt: begin
          if (fld == `GBT_FRAME_START) begin
            state    <= gbt_link_pkg::st_frame;
            word_cnt <= 4'd1; // next word is the begin word
          end
        end
        gbt_link_pkg::st_frame: begin
          word_cnt <= word_cnt + 4'd1;
          if (word_cnt == 4'd1) begin
            wr_valid_q <= fld[5];
            rsvd_err_q <= |fld[3:0];
          end
          if (word_cnt == LAST_CNT) begin // data4, frame done
            state       <= gbt_link_pkg::st_hunt;
            req_stb_o   <= wr_valid_q & ~rsvd_err_q;
            frame_err_o <= rsvd_err_q;
          end
        end
        default: state <= gbt_link_pkg::st_hunt;
      endcase
    end
  end

  // ------------------------------
  // field assembly
  // ------------------------------

  always_ff @(posedge clk40) begin
    if (state == gbt_link_pkg::st_frame) begin
      case (word_cnt)
        4'd1: wr_en_q <= fld[4];
        4'd2: addr_q[15:10] <= fld;
        4'd3: addr_q[9:4]   <= fld;
        4'd4: begin
          addr_q[3:0] <= fld[5:2];
          data_q      <= {30'd0, fld[1:0]}; // data bits 31..30
        end
        LAST_CNT: begin // hand the request over, stable with the strobe
          req_wr_o   <= wr_en_q;
          req_addr_o <= addr_q;
          req_data_o <= {data_q[25:0], fld};
        end
        default: data_q <= {data_q[25:0], fld}; // data0..data3
      endcase
    end
  end

  // request or frame error only ten words after a start code
  a_frame_end: assert property (@(posedge clk40) disable iff (!rst_n_i)
    (req_stb_o || frame_err_o) |-> ($past(fld, `GBT_FRAME_WORDS) == `GBT_FRAME_START))
    else $error("strobe without a start code one frame earlier");

  // requests are at least a frame apart
  a_stb_spacing: assert property (@(posedge clk40) disable iff (!rst_n_i)
    req_stb_o |=> !req_stb_o)
    else $error("req_stb_o high in two consecutive cycles");

endmodule

`default_nettype wire

//--- common/gbt_link_pkg.sv
`default_nettype none

package gbt_link_pkg;

  // ------------------------------
  // link words and fields
  // ------------------------------

  // one word per clk40, ttc nibble on top, frame field below
  typedef logic [9:0] elink_word_t;

  typedef logic [5:0] frame_field_t; // lower 6 bits of a link word

  // {l1a, calpulse, resync, bc0}
  typedef logic [3:0] ttc_cmd_t;

  // ------------------------------
  // request / reply payload
  // ------------------------------

  typedef logic [15:0] reg_addr_t; // full request address
  typedef logic [31:0] reg_data_t; // register data

  // upper nibble of every reply word
  typedef logic [3:0] reply_seq_t;

  // ------------------------------
  // decoder fsm
  // ------------------------------

  typedef enum logic {
    st_hunt,  // looking for the start code
    st_frame  // counting through the 9 words after it
  } dec_state_t;

endpackage

`default_nettype wire

//--- common/gbt_link_defines.svh
`ifndef GBT_LINK_DEFINES_SVH
`define GBT_LINK_DEFINES_SVH

// ------------------------------
// e-link frame format
// ------------------------------

// start code, first word of every request and reply frame
`define GBT_FRAME_START 6'h2A

// start, begin, 3 addr, 5 data
`define GBT_FRAME_WORDS 10

// ------------------------------
// register bank
// ------------------------------

`define GBT_REG_COUNT 16 // number of 32 bit registers
`define GBT_REG_IDX_W 4  // low address bits that select a register

`endif
